//--- rtl/support_pkg.sv
// reset support package

package support_pkg;

   // infrastructure reset sequence, 3'd5 left unused
   typedef enum logic [2:0] {
      r_init   = 3'd0, // power-on, memory reset after holdoff
      r_reset1 = 3'd1, // restart entry, memory reset
      r_reset2 = 3'd2,
      r_reset3 = 3'd3, // waiting on memory calibration
      r_reset4 = 3'd4, // cpu sequence start
      r_wait   = 3'd6, // reset released
      r_idle   = 3'd7  // system up
   } reset_state_t;

   // cpu reset and boot window, 3'd7 left unused
   typedef enum logic [2:0] {
      c_init   = 3'd0,
      c_reset1 = 3'd1,
      c_reset2 = 3'd2,
      c_reset3 = 3'd3, // reset and boot overlap
      c_boot   = 3'd4,
      c_wait   = 3'd5, // waiting for system idle
      c_idle   = 3'd6  // cpu running
   } cpu_state_t;

   typedef logic [15:0] cycle_count_t; // sysclk cycle counts
   typedef logic [15:0] press_hist_t;  // button sample history

endpackage

//--- rtl/tick_gen.sv
// tick divider chain
`timescale 1ns/1ns

module tick_gen #(
   parameter int MED_DIV_BITS  = 6,
   parameter int SLOW_DIV_BITS = 12,
   parameter int CPU_DIV_BITS  = 2
) (
   input  logic sysclk,
   input  logic dcm_reset,
   output logic med_tick,
   output logic slow_tick,
   output logic cpu_tick
);

   logic [MED_DIV_BITS-1:0]  med_cnt;
   logic [SLOW_DIV_BITS-1:0] slow_cnt;
   logic [CPU_DIV_BITS-1:0]  cpu_cnt;

   // free-running, all three start together out of reset
   always_ff @(posedge sysclk or posedge dcm_reset)
   begin
      if (dcm_reset)
      begin
         med_cnt  <= '0;
         slow_cnt <= '0;
         cpu_cnt  <= '0;
      end
      else
      begin
         med_cnt  <= med_cnt + 1'b1;
         slow_cnt <= slow_cnt + 1'b1;
         cpu_cnt  <= cpu_cnt + 1'b1;
      end
   end

   assign med_tick  = &med_cnt;  // one cycle per medium period
   assign slow_tick = &slow_cnt; // debounce sample strobe
   assign cpu_tick  = &cpu_cnt;

   // cpu period must divide the medium period so cpu_start always sees a cpu tick
   a_cpu_in_med : assert property (@(posedge sysclk) disable iff (dcm_reset)
      med_tick |-> cpu_tick);

endmodule

//--- rtl/button_debounce.sv
// push button debounce
`timescale 1ns/1ns

module button_debounce #(
   parameter int HOLD_LEN = 10
) (
   input  logic sysclk,
   input  logic dcm_reset,
   input  logic slow_tick,
   input  logic button_r,
   output logic press
);

   import support_pkg::*;

   press_hist_t hist;      // newest sample in bit 0
   logic        detected;
   logic        press_history; // detection seen at the previous sample

   always_ff @(posedge sysclk or posedge dcm_reset)
   begin
      if (dcm_reset)
      begin
         hist          <= '0;
         press_history <= 1'b0;
      end
      else if (slow_tick)
      begin
         hist          <= {hist[14:0], button_r};
         press_history <= detected;
      end
   end

   // button counts as down after HOLD_LEN high samples in a row
   assign detected = &hist[HOLD_LEN-1:0];

   // rising edge of detection, one cycle wide
   assign press = slow_tick && detected && !press_history;

   a_press_single : assert property (@(posedge sysclk) disable iff (dcm_reset)
      press |=> !press);

endmodule

//--- rtl/reset_sequencer.sv
// infrastructure reset sequencer
`timescale 1ns/1ns

module reset_sequencer #(
   parameter support_pkg::cycle_count_t HOLDOFF = 16'd4
) (
   input  logic sysclk,
   input  logic dcm_reset,
   input  logic med_tick,
   input  logic press,
   input  logic lpddr_calib_done,
   input  logic cpu_busy,
   output logic lpddr_reset,
   output logic infra_hold,
   output logic cpu_start,
   output logic sys_idle
);

   import support_pkg::*;

   reset_state_t state;
   reset_state_t state_next;
   cycle_count_t holdoff_cnt;
   logic         holdoff_done;
   logic         pending; // press waiting for a medium tick

   // counts only once after power-up, then parks at HOLDOFF
   always_ff @(posedge sysclk or posedge dcm_reset)
   begin
      if (dcm_reset)
         holdoff_cnt <= '0;
      else if (!holdoff_done)
         holdoff_cnt <= holdoff_cnt + 1'b1;
   end

   assign holdoff_done = (holdoff_cnt == HOLDOFF);

   // a press landing on a tick cycle survives to the following tick
   always_ff @(posedge sysclk or posedge dcm_reset)
   begin
      if (dcm_reset)
         pending <= 1'b0;
      else if (press)
         pending <= 1'b1;
      else if (med_tick)
         pending <= 1'b0;
   end

   always_comb
   begin
      state_next = state;
      case (state)
         r_init   : state_next = r_reset1;
         r_reset1 : state_next = r_reset2;
         r_reset2 : state_next = r_reset3;
         r_reset3 : if (lpddr_calib_done) state_next = r_reset4;
         r_reset4 : if (cpu_busy) state_next = r_wait;   // cpu has taken the start
         r_wait   : if (!pending) state_next = r_idle;
         r_idle   : if (pending) state_next = r_reset1;  // restart from button
         default  : state_next = r_init;
      endcase
   end

   always_ff @(posedge sysclk or posedge dcm_reset)
   begin
      if (dcm_reset)
         state <= r_init;
      else if (med_tick)
         state <= state_next;
   end

   assign lpddr_reset = (state == r_init || state == r_reset1) && holdoff_done;
   assign infra_hold  = (state == r_init) || (state == r_reset1) ||
                        (state == r_reset2) || (state == r_reset3);
   assign cpu_start   = (state == r_reset4);
   assign sys_idle    = (state == r_idle);

   a_state_legal : assert property (@(posedge sysclk) disable iff (dcm_reset)
      state != reset_state_t'(3'd5));

   // memory reset ends only with the step on to r_reset2
   a_lpddr_window : assert property (@(posedge sysclk) disable iff (dcm_reset)
      $fell(lpddr_reset) |-> (state == r_reset2));

endmodule

//--- rtl/cpu_sequencer.sv
// cpu reset and boot sequencer
`timescale 1ns/1ns

module cpu_sequencer (
   input  logic sysclk,
   input  logic dcm_reset,
   input  logic cpu_tick,
   input  logic infra_hold,
   input  logic cpu_start,
   input  logic sys_idle,
   output logic cpu_busy,
   output logic reset,
   output logic boot
);

   import support_pkg::*;

   cpu_state_t state;
   cpu_state_t state_next;

   always_comb
   begin
      state_next = state;
      case (state)
         c_init   : if (cpu_start) state_next = c_reset1;
         c_reset1 : state_next = c_reset2;
         c_reset2 : state_next = c_reset3;
         c_reset3 : state_next = c_boot;
         c_boot   : state_next = c_wait;
         c_wait   : if (sys_idle) state_next = c_idle;
         c_idle   : if (cpu_start) state_next = c_reset1; // button restart
         default  : state_next = c_init;
      endcase
   end

   always_ff @(posedge sysclk or posedge dcm_reset)
   begin
      if (dcm_reset)
         state <= c_init;
      else if (cpu_tick)
         state <= state_next;
   end

   assign cpu_busy = (state != c_idle);

   // infrastructure hold keeps the cpu in reset too
   assign reset = infra_hold || (state == c_init) || (state == c_reset1) ||
                  (state == c_reset2) || (state == c_reset3) ||
                  (state == c_idle && cpu_start); // restart start not yet taken

   // two cpu periods, the first one overlapping reset
   assign boot = (state == c_reset3) || (state == c_boot);

   // boot only once the memory side is out of reset
   a_boot_after_infra : assert property (@(posedge sysclk) disable iff (dcm_reset)
      !(boot && infra_hold));

endmodule

//--- rtl/support_top.sv
// reset support top level
`timescale 1ns/1ns

module support_top #(
   parameter int                       MED_DIV_BITS  = 6,
   parameter int                       SLOW_DIV_BITS = 12,
   parameter int                       CPU_DIV_BITS  = 2,
   parameter int                       HOLD_LEN      = 10,
   parameter support_pkg::cycle_count_t HOLDOFF      = 16'd4
) (
   input  logic sysclk,
   input  logic dcm_reset,
   input  logic button_r,
   input  logic lpddr_calib_done,
   output logic lpddr_reset,
   output logic reset,
   output logic boot
);

   logic med_tick;
   logic slow_tick;
   logic cpu_tick;
   logic press;
   logic infra_hold;
   logic cpu_start;
   logic sys_idle;
   logic cpu_busy;

   tick_gen #(
      .MED_DIV_BITS  (MED_DIV_BITS),
      .SLOW_DIV_BITS (SLOW_DIV_BITS),
      .CPU_DIV_BITS  (CPU_DIV_BITS)
   ) u_tick_gen (
      .sysclk    (sysclk),
      .dcm_reset (dcm_reset),
      .med_tick  (med_tick),
      .slow_tick (slow_tick),
      .cpu_tick  (cpu_tick)
   );

   button_debounce #(
      .HOLD_LEN (HOLD_LEN)
   ) u_button_debounce (
      .sysclk    (sysclk),
      .dcm_reset (dcm_reset),
      .slow_tick (slow_tick),
      .button_r  (button_r),
      .press     (press)
   );

   reset_sequencer #(
      .HOLDOFF (HOLDOFF)
   ) u_reset_sequencer (
      .sysclk           (sysclk),
      .dcm_reset        (dcm_reset),
      .med_tick         (med_tick),
      .press            (press),
      .lpddr_calib_done (lpddr_calib_done),
      .cpu_busy         (cpu_busy),
      .lpddr_reset      (lpddr_reset),
      .infra_hold       (infra_hold),
      .cpu_start        (cpu_start),
      .sys_idle         (sys_idle)
   );

   cpu_sequencer u_cpu_sequencer (
      .sysclk     (sysclk),
      .dcm_reset  (dcm_reset),
      .cpu_tick   (cpu_tick),
      .infra_hold (infra_hold),
      .cpu_start  (cpu_start),
      .sys_idle   (sys_idle),
      .cpu_busy   (cpu_busy),
      .reset      (reset),
      .boot       (boot)
   );

endmodule

//--- tb/support_tb.sv
// reset support testbench
`timescale 1ns/1ns

module support_tb;

   import support_pkg::*;

   localparam int           MED_DIV_BITS  = 3;
   localparam int           SLOW_DIV_BITS = 2;
   localparam int           CPU_DIV_BITS  = 1;
   localparam int           HOLD_LEN      = 3;
   localparam cycle_count_t HOLDOFF       = 16'd4;
   localparam int           QUIET         = 4 << MED_DIV_BITS; // idle outputs end a case
   localparam int           SEQ_BOUND     = 300;               // cycles per case beyond inputs

   logic sysclk;
   logic dcm_reset;
   logic button_r;
   logic lpddr_calib_done;
   logic lpddr_reset;
   logic reset;
   logic boot;

   string case_name[$];
   int    calib_q[$];
   int    press_q[$];
   int    restart_q[$];
   string cur_name;
   int    budget = 0;

   // per-case view of the outputs
   int   cyc;
   int   last_event;
   int   boot_rise;
   int   restarts;
   int   boots;
   logic up;          // first boot window finished
   logic first_lp;
   logic lp_allowed;  // memory reset legal until the next boot
   logic lp_seen;
   logic prev_reset;
   logic prev_boot;
   logic prev_lp;

   support_top #(
      .MED_DIV_BITS  (MED_DIV_BITS),
      .SLOW_DIV_BITS (SLOW_DIV_BITS),
      .CPU_DIV_BITS  (CPU_DIV_BITS),
      .HOLD_LEN      (HOLD_LEN),
      .HOLDOFF       (HOLDOFF)
   ) DUT (
      .sysclk           (sysclk),
      .dcm_reset        (dcm_reset),
      .button_r         (button_r),
      .lpddr_calib_done (lpddr_calib_done),
      .lpddr_reset      (lpddr_reset),
      .reset            (reset),
      .boot             (boot)
   );

   initial
   begin
      sysclk = 1'b0;
      forever #20 sysclk = ~sysclk;
   end

   task automatic check_bit(input string label, input logic expected, input logic actual);
      if (actual !== expected)
      begin
         $display("[ERROR] %s %s: expected %b, actual %b", cur_name, label, expected, actual);
         $display("TEST FAILED");
         $fatal(1, "bit mismatch");
      end
   endtask

   task automatic check_count(input string label, input cycle_count_t expected,
                              input cycle_count_t actual);
      if (actual !== expected)
      begin
         $display("[ERROR] %s %s: expected %0d, actual %0d", cur_name, label, expected, actual);
         $display("TEST FAILED");
         $fatal(1, "count mismatch");
      end
   endtask

   // outputs settled since the rising edge
   task automatic observe();
      if (reset && !prev_reset)
      begin
         check_bit("reset rise only after boot", 1'b1, up);
         restarts++;
         lp_allowed = 1'b1; // restart reopens the memory reset window
      end
      if (lpddr_reset)
      begin
         if (!first_lp)
         begin
            check_count("lpddr_reset holdoff", HOLDOFF, cycle_count_t'(cyc));
            first_lp = 1'b1;
         end
         check_bit("lpddr_reset outside window", 1'b1, lp_allowed);
         lp_seen = 1'b1;
      end
      if (!lpddr_calib_done)
         check_bit("reset during calibration", 1'b1, reset);
      if (boot && !prev_boot)
      begin
         check_bit("boot before calibration", 1'b1, lpddr_calib_done);
         check_bit("lpddr_reset pulse before boot", 1'b1, lp_seen);
         lp_seen    = 1'b0;
         lp_allowed = 1'b0;
         boot_rise  = cyc;
         boots++;
      end
      if (!reset && prev_reset)
      begin
         check_bit("boot at reset fall", 1'b1, boot);
         check_count("reset fall after boot rise", cycle_count_t'(1 << CPU_DIV_BITS),
                     cycle_count_t'(cyc - boot_rise));
      end
      if (!boot && prev_boot)
      begin
         check_count("boot pulse length", cycle_count_t'(2 << CPU_DIV_BITS),
                     cycle_count_t'(cyc - boot_rise));
         check_bit("reset after boot", 1'b0, reset);
         up = 1'b1;
      end
      if (reset !== prev_reset || boot !== prev_boot || lpddr_reset !== prev_lp)
         last_event = cyc;
      prev_reset = reset;
      prev_boot  = boot;
      prev_lp    = lpddr_reset;
   endtask

   task automatic step();
      @(negedge sysclk);
      cyc++;
      observe();
   endtask

   task automatic load_cases();
      int    fd;
      int    n;
      int    calib;
      int    press;
      int    rst;
      int    total;
      string tok;
      reg [8*128-1:0] rest;
      total = 0;
      fd = $fopen("tb/support_cases.txt", "r");
      if (fd == 0)
      begin
         $display("could not open tb/support_cases.txt");
         $display("TEST FAILED");
         $fatal(1, "no case file");
      end
      while (!$feof(fd))
      begin
         n = $fscanf(fd, " %s", tok);
         if (n == 1 && tok[0] == "#")
            n = $fgets(rest, fd); // column notes
         else if (n == 1)
         begin
            n = $fscanf(fd, " %d %d %d", calib, press, rst);
            if (n != 3)
            begin
               $display("case line %s is incomplete", tok);
               $display("TEST FAILED");
               $fatal(1, "bad case line");
            end
            case_name.push_back(tok);
            calib_q.push_back(calib);
            press_q.push_back(press);
            restart_q.push_back(rst);
            total += calib + (press << SLOW_DIV_BITS) + SEQ_BOUND;
         end
      end
      $fclose(fd);
      if (total == 0)
      begin
         $display("the case file holds no cases");
         $display("TEST FAILED");
         $fatal(1, "empty case file");
      end
      budget = total;
   endtask

   task automatic run_case(input int idx);
      int calib_delay;
      int press_len;
      int expected;
      calib_delay = calib_q[idx];
      press_len   = press_q[idx];
      expected    = restart_q[idx];
      cur_name    = case_name[idx];
      @(negedge sysclk);
      dcm_reset        = 1'b1;
      button_r         = 1'b0;
      lpddr_calib_done = 1'b0;
      repeat (10) @(negedge sysclk);
      dcm_reset  = 1'b0;
      cyc        = 0;
      last_event = 0;
      boot_rise  = 0;
      restarts   = 0;
      boots      = 0;
      up         = 1'b0;
      first_lp   = 1'b0;
      lp_allowed = 1'b1;
      lp_seen    = 1'b0;
      prev_reset = reset;
      prev_boot  = boot;
      prev_lp    = lpddr_reset;
      lpddr_calib_done = (calib_delay == 0);
      while (!up)
      begin
         step();
         if (cyc >= calib_delay)
            lpddr_calib_done = 1'b1;
      end
      repeat (2 << MED_DIV_BITS) step(); // let the cpu side reach idle
      if (press_len > 0)
      begin
         button_r = 1'b1;
         repeat (press_len << SLOW_DIV_BITS) step();
         button_r = 1'b0;
         last_event = cyc; // quiet window counts from the release
      end
      while (cyc - last_event < QUIET)
         step();
      check_count("restarts", cycle_count_t'(expected), cycle_count_t'(restarts));
      check_count("boot pulses", cycle_count_t'(expected + 1), cycle_count_t'(boots));
      check_bit("reset at end", 1'b0, reset);
   endtask

   initial
   begin
      dcm_reset        = 1'b1;
      button_r         = 1'b0;
      lpddr_calib_done = 1'b0;
      load_cases();
      foreach (case_name[i])
         run_case(i);
      $display("TEST PASSED");
      $finish;
   end

   // budget grows with calibration delays and press lengths
   initial
   begin
      wait (budget > 0);
      repeat (budget) @(posedge sysclk);
      $display("reset sequence hung, %0d cycles used up in case %s", budget, cur_name);
      $display("TEST FAILED");
      $fatal(1, "timeout");
   end

endmodule

//--- tb/support_cases.txt
# name calib_delay press_len restarts
# calib_delay in sysclk cycles after reset, press_len in slow ticks (0 = no press)
boot_only_fast_calib 0 0 0
boot_only_calib_early 7 0 0
boot_only_calib_edge 24 0 0
boot_only_calib_late 57 0 0
boot_only_calib_very_late 150 0 0
short_press_one_tick 12 1 0
short_press_two_ticks 33 2 0
short_press_late_calib 90 2 0
press_exact_hold 5 3 1
press_exact_late_calib 41 3 1
press_four_ticks 0 4 1
press_long 20 12 1
press_very_long 3 40 1
press_long_late_calib 120 25 1
press_odd_calib 31 7 1
press_calib_edge 25 5 1

//--- list.f
rtl/support_pkg.sv
rtl/tick_gen.sv
rtl/button_debounce.sv
rtl/reset_sequencer.sv
rtl/cpu_sequencer.sv
rtl/support_top.sv
tb/support_tb.sv

//--- run.sh
#!/bin/sh
# build and run the reset support simulation with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
   -f list.f \
   --top-module support_tb \
   -Mdir obj_dir -o support_sim
./obj_dir/support_sim
